//--- Bender.yml
package:
  name: lc4_pipeline

sources:
  - include_dirs:
      - hw
    files:
      - hw/lc4_pkg.sv
      - hw/lc4_stage_if.sv
      - hw/lc4_fetch.sv
      - hw/lc4_decode.sv
      - hw/lc4_execute.sv
      - hw/lc4_memory.sv
      - hw/lc4_writeback.sv
      - hw/lc4_pipeline.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - tb/lc4_ref_model.sv
      - tb/lc4_tb.sv

//--- hw/lc4_decode.sv
`include "lc4_defs.svh"

module lc4_decode (
  input  logic              gwe,
  input  logic              i_rst,
  input  logic              i_flush,    // Taken branch kills the decode slot
  input  logic              i_wb_we,    // Register-file write from writeback
  input  lc4_pkg::reg_sel_t i_wb_rd,
  input  lc4_pkg::word_t    i_wb_data,
  output logic              o_stall,    // Load-use hold to fetch
  lc4_stage_if.dst          fd,
  lc4_stage_if.src          dx
);

  lc4_pkg::ctrl_t    ctrl;
  lc4_pkg::reg_sel_t rs;
  lc4_pkg::reg_sel_t rt;
  lc4_pkg::reg_sel_t rd;
  lc4_pkg::word_t    rf [8];   // R0..R7
  lc4_pkg::word_t    rs_data;
  lc4_pkg::word_t    rt_data;
  logic              bubble;
  logic              use_hit;

  // Subset decoder, anything else leaves ctrl clear
  always_comb begin
    ctrl = '0;
    rs   = fd.insn[8:6];
    rt   = fd.insn[2:0];
    rd   = fd.insn[11:9];
    case (fd.insn[15:12])
      `LC4_OP_BR: ctrl.is_branch = 1'b1;
      `LC4_OP_ARITH, `LC4_OP_LOGIC: begin
        // ADD and AND share a subcode
        if (fd.insn[`LC4_IMM_BIT] || fd.insn[5:3] == `LC4_SUB_ADD) begin
          ctrl.rs_re  = 1'b1;
          ctrl.rt_re  = !fd.insn[`LC4_IMM_BIT];
          ctrl.rf_we  = 1'b1;
          ctrl.nzp_we = 1'b1;
        end
      end
      `LC4_OP_LDR: begin
        ctrl.rs_re   = 1'b1;
        ctrl.rf_we   = 1'b1;
        ctrl.nzp_we  = 1'b1;
        ctrl.is_load = 1'b1;
      end
      `LC4_OP_STR: begin
        rt             = fd.insn[11:9];   // Store data sits in the rd field
        ctrl.rs_re     = 1'b1;
        ctrl.rt_re     = 1'b1;
        ctrl.is_store  = 1'b1;
      end
      `LC4_OP_CONST: begin
        ctrl.rf_we    = 1'b1;
        ctrl.nzp_we   = 1'b1;
        ctrl.is_const = 1'b1;
      end
      default: ctrl = '0;
    endcase
  end

  // Register file, write-through so a same-cycle writer is seen here
  always_ff @(posedge gwe) begin
    if (i_wb_we) rf[i_wb_rd] <= i_wb_data;
  end

  assign rs_data = (i_wb_we && i_wb_rd == rs) ? i_wb_data : rf[rs];
  assign rt_data = (i_wb_we && i_wb_rd == rt) ? i_wb_data : rf[rt];

  // Load one ahead feeds a source read here, store data included
  assign use_hit = (ctrl.rs_re && rs == dx.rd) || (ctrl.rt_re && rt == dx.rd);
  assign o_stall = fd.valid && dx.valid && dx.ctrl.is_load && use_hit;
  assign bubble  = !fd.valid || o_stall || i_flush;

  // Decode-to-execute register
  always_ff @(posedge gwe) begin
    if (i_rst) begin
      dx.valid <= 1'b0;
      dx.ctrl  <= '0;
    end else begin
      dx.valid <= !bubble;
      dx.ctrl  <= bubble ? '0 : ctrl;   // Bubbles carry no control
    end
  end

  always_ff @(posedge gwe) begin
    dx.pc   <= fd.pc;
    dx.insn <= bubble ? `LC4_NOP_INSN : fd.insn;
    dx.rs   <= rs;
    dx.rt   <= rt;
    dx.rd   <= rd;
    dx.a    <= rs_data;
    dx.b    <= rt_data;
  end

endmodule

//--- hw/lc4_defs.svh
`ifndef LC4_DEFS_SVH
`define LC4_DEFS_SVH

// First fetch address after reset
`define LC4_RESET_PC 16'h8200

// Opcodes in insn[15:12]
`define LC4_OP_BR    4'b0000
`define LC4_OP_ARITH 4'b0001
`define LC4_OP_LOGIC 4'b0101
`define LC4_OP_LDR   4'b0110
`define LC4_OP_STR   4'b0111
`define LC4_OP_CONST 4'b1001

// Register-form subcodes in insn[5:3]
`define LC4_SUB_ADD 3'b000  // Under ARITH
`define LC4_SUB_AND 3'b000  // Under LOGIC

// Immediate-form select for ADD and AND
`define LC4_IMM_BIT 5

// BR with empty mask, never taken
// Used as the bubble filler
`define LC4_NOP_INSN 16'h0000

`endif

//--- hw/lc4_execute.sv
`include "lc4_defs.svh"

module lc4_execute (
  input  logic              gwe,
  input  logic              i_rst,
  input  logic              i_m_we,     // Memory stage writes a register
  input  lc4_pkg::reg_sel_t i_m_rd,
  input  lc4_pkg::word_t    i_m_data,
  input  lc4_pkg::nzp_t     i_m_nzp,    // NZP of memory's value
  input  logic              i_w_we,     // Writeback stage writes a register
  input  lc4_pkg::reg_sel_t i_w_rd,
  input  lc4_pkg::word_t    i_w_data,
  input  lc4_pkg::nzp_t     i_w_nzp,    // NZP after writeback's instruction
  output logic              o_redirect,
  output lc4_pkg::word_t    o_target,
  lc4_stage_if.dst          dx,
  lc4_stage_if.src          xm
);

  lc4_pkg::word_t op_a;
  lc4_pkg::word_t op_b;
  lc4_pkg::word_t op_2;     // Second ALU input from a register or imm5
  lc4_pkg::word_t result;
  lc4_pkg::nzp_t  nzp_cur;

  // Youngest older writer wins
  function automatic lc4_pkg::word_t bypass(input lc4_pkg::reg_sel_t r,
                                            input lc4_pkg::word_t rf_val);
    lc4_pkg::word_t v;
    if (i_m_we && i_m_rd == r)      v = i_m_data;
    else if (i_w_we && i_w_rd == r) v = i_w_data;
    else                            v = rf_val;
    return v;
  endfunction

  always_comb begin
    op_a = bypass(dx.rs, dx.a);
    op_b = bypass(dx.rt, dx.b);
  end

  assign op_2 = dx.insn[`LC4_IMM_BIT] ? {{11{dx.insn[4]}}, dx.insn[4:0]} : op_b;

  always_comb begin
    case (dx.insn[15:12])
      `LC4_OP_ARITH: result = op_a + op_2;
      `LC4_OP_LOGIC: result = op_a & op_2;
      `LC4_OP_LDR, `LC4_OP_STR: result = op_a + {{10{dx.insn[5]}}, dx.insn[5:0]};
      `LC4_OP_CONST: result = {{7{dx.insn[8]}}, dx.insn[8:0]};
      default:       result = '0;    // BR and dropped opcodes
    endcase
  end

  // Every register writer in the subset also sets NZP
  assign nzp_cur    = i_m_we ? i_m_nzp : i_w_nzp;
  assign o_target   = dx.pc + 16'd1 + {{7{dx.insn[8]}}, dx.insn[8:0]};
  assign o_redirect = dx.valid && dx.ctrl.is_branch && |(dx.insn[11:9] & nzp_cur);

  // Execute-to-memory register
  always_ff @(posedge gwe) begin
    if (i_rst) begin
      xm.valid <= 1'b0;
      xm.ctrl  <= '0;
    end else begin
      xm.valid <= dx.valid;
      xm.ctrl  <= dx.ctrl;
    end
  end

  always_ff @(posedge gwe) begin
    xm.pc   <= dx.pc;
    xm.insn <= dx.insn;
    xm.rs   <= dx.rs;
    xm.rt   <= dx.rt;
    xm.rd   <= dx.rd;
    xm.a    <= result;      // ALU value or memory address
    xm.b    <= op_b;        // Store data
  end

endmodule

//--- hw/lc4_fetch.sv
`include "lc4_defs.svh"

module lc4_fetch (
  input  logic           gwe,
  input  logic           i_rst,
  input  logic           i_stall,       // Load-use hold from decode
  input  logic           i_redirect,    // Taken branch in execute
  input  lc4_pkg::word_t i_target,      // Branch target
  input  lc4_pkg::word_t i_imem_rdata,  // Instruction at o_imem_addr
  output lc4_pkg::word_t o_imem_addr,
  lc4_stage_if.src       fd
);

  lc4_pkg::word_t pc_q;
  lc4_pkg::word_t pc_next;

  // Redirect beats hold, hold beats sequential
  always_comb begin
    if (i_redirect) begin
      pc_next = i_target;
    end else if (i_stall) begin
      pc_next = pc_q;           // Refetch same word
    end else begin
      pc_next = pc_q + 16'd1;
    end
  end

  always_ff @(posedge gwe) begin
    if (i_rst) pc_q <= `LC4_RESET_PC;
    else       pc_q <= pc_next;
  end

  assign o_imem_addr = pc_q;

  // Fetch-to-decode register, frozen while decode holds
  always_ff @(posedge gwe) begin
    if (i_rst || i_redirect) fd.valid <= 1'b0;  // Wrong-path word dropped
    else if (!i_stall)       fd.valid <= 1'b1;
  end

  always_ff @(posedge gwe) begin
    if (!i_stall) begin
      fd.pc   <= pc_q;
      fd.insn <= i_imem_rdata;
    end
  end

  // Nothing decoded yet at this point
  assign fd.ctrl = '0;
  assign fd.rs   = '0;
  assign fd.rt   = '0;
  assign fd.rd   = '0;
  assign fd.a    = '0;
  assign fd.b    = '0;

  // Decode stalls only behind a load, execute redirects only on a branch
  a_no_stall_and_redirect : assert property (
    @(posedge gwe) disable iff (i_rst) !(i_redirect && i_stall));

endmodule

//--- hw/lc4_memory.sv
module lc4_memory (
  input  logic              gwe,
  input  logic              i_rst,
  input  lc4_pkg::word_t    i_dmem_rdata,   // Same-cycle read of o_dmem_addr
  output lc4_pkg::word_t    o_dmem_addr,
  output lc4_pkg::word_t    o_dmem_wdata,
  output logic              o_dmem_we,
  output logic              o_byp_we,
  output lc4_pkg::reg_sel_t o_byp_rd,
  output lc4_pkg::word_t    o_byp_data,
  output lc4_pkg::nzp_t     o_nzp,
  lc4_stage_if.dst          xm,
  lc4_stage_if.src          mw
);

  logic           is_mem;
  lc4_pkg::word_t value;   // What this instruction hands to writeback

  assign is_mem       = xm.valid && (xm.ctrl.is_load || xm.ctrl.is_store);
  assign o_dmem_addr  = is_mem ? xm.a : '0;     // Zero for non-memory insns
  assign o_dmem_we    = xm.valid && xm.ctrl.is_store;
  assign o_dmem_wdata = o_dmem_we ? xm.b : '0;

  always_comb begin
    if (xm.ctrl.is_load)       value = i_dmem_rdata;
    else if (xm.ctrl.is_store) value = xm.b;   // Shown on the trace only
    else                       value = xm.a;
  end

  // Back to execute
  assign o_byp_we   = xm.valid && xm.ctrl.rf_we;
  assign o_byp_rd   = xm.rd;
  assign o_byp_data = value;
  assign o_nzp      = lc4_pkg::nzp_of(value);

  // Memory-to-writeback register
  always_ff @(posedge gwe) begin
    if (i_rst) begin
      mw.valid <= 1'b0;
      mw.ctrl  <= '0;
    end else begin
      mw.valid <= xm.valid;
      mw.ctrl  <= xm.ctrl;
    end
  end

  always_ff @(posedge gwe) begin
    mw.pc   <= xm.pc;
    mw.insn <= xm.insn;
    mw.rs   <= xm.rs;
    mw.rt   <= xm.rt;
    mw.rd   <= xm.rd;
    mw.a    <= value;
    mw.b    <= o_dmem_addr;   // Kept for the trace
  end

endmodule

//--- hw/lc4_pipeline.sv
module lc4_pipeline (
  input  logic              gwe,
  input  logic              i_rst,
  output lc4_pkg::word_t    o_imem_addr,
  input  lc4_pkg::word_t    i_imem_rdata,
  output lc4_pkg::word_t    o_dmem_addr,
  output lc4_pkg::word_t    o_dmem_wdata,
  output logic              o_dmem_we,
  input  lc4_pkg::word_t    i_dmem_rdata,
  output logic              o_wb_valid,
  output lc4_pkg::word_t    o_wb_pc,
  output lc4_pkg::word_t    o_wb_insn,
  output logic              o_wb_rf_we,
  output lc4_pkg::reg_sel_t o_wb_rd,
  output lc4_pkg::word_t    o_wb_data,
  output lc4_pkg::nzp_t     o_wb_nzp,
  output logic              o_wb_dmem_we,
  output lc4_pkg::word_t    o_wb_dmem_addr,
  output lc4_pkg::word_t    o_wb_dmem_data
);

  lc4_stage_if fd ();
  lc4_stage_if dx ();
  lc4_stage_if xm ();
  lc4_stage_if mw ();

  logic              stall;
  logic              redirect;
  lc4_pkg::word_t    target;
  logic              m_we;       // Memory-stage bypass
  lc4_pkg::reg_sel_t m_rd;
  lc4_pkg::word_t    m_data;
  lc4_pkg::nzp_t     m_nzp;
  logic              w_we;       // Writeback port, also the W bypass
  lc4_pkg::reg_sel_t w_rd;
  lc4_pkg::word_t    w_data;
  lc4_pkg::nzp_t     w_nzp;

  lc4_fetch i_fetch (.gwe, .i_rst, .i_stall(stall), .i_redirect(redirect),
                     .i_target(target), .i_imem_rdata, .o_imem_addr, .fd(fd.src));

  lc4_decode i_decode (.gwe, .i_rst, .i_flush(redirect), .i_wb_we(w_we), .i_wb_rd(w_rd),
                       .i_wb_data(w_data), .o_stall(stall), .fd(fd.dst), .dx(dx.src));

  lc4_execute i_execute (.gwe, .i_rst, .i_m_we(m_we), .i_m_rd(m_rd), .i_m_data(m_data),
                         .i_m_nzp(m_nzp), .i_w_we(w_we), .i_w_rd(w_rd), .i_w_data(w_data),
                         .i_w_nzp(w_nzp), .o_redirect(redirect), .o_target(target),
                         .dx(dx.dst), .xm(xm.src));

  lc4_memory i_memory (.gwe, .i_rst, .i_dmem_rdata, .o_dmem_addr, .o_dmem_wdata, .o_dmem_we,
                       .o_byp_we(m_we), .o_byp_rd(m_rd), .o_byp_data(m_data),
                       .o_nzp(m_nzp), .xm(xm.dst), .mw(mw.src));

  lc4_writeback i_writeback (.gwe, .i_rst, .o_rf_we(w_we), .o_rd(w_rd), .o_wdata(w_data),
                             .o_nzp(w_nzp), .o_wb_valid, .o_wb_pc, .o_wb_insn, .o_wb_rf_we,
                             .o_wb_rd, .o_wb_data, .o_wb_nzp, .o_wb_dmem_we,
                             .o_wb_dmem_addr, .o_wb_dmem_data, .mw(mw.dst));

endmodule

//--- hw/lc4_pkg.sv
package lc4_pkg;

  typedef logic [15:0] word_t;     // Data word or address
  typedef logic [2:0]  reg_sel_t;  // Register number R0..R7
  typedef logic [2:0]  nzp_t;      // Negative, zero, positive

  // Decoded control, one flag per field
  typedef struct packed {
    logic rs_re;      // Reads rs
    logic rt_re;      // Reads rt
    logic rf_we;      // Writes rd
    logic nzp_we;     // Sets condition codes
    logic is_load;
    logic is_store;
    logic is_branch;
    logic is_const;
  } ctrl_t;

  // Condition codes of a written value
  function automatic nzp_t nzp_of(input word_t v);
    nzp_t n;
    if (v[15]) begin
      n = 3'b100;
    end else if (v == '0) begin
      n = 3'b010;
    end else begin
      n = 3'b001;
    end
    return n;
  endfunction

endpackage

//--- hw/lc4_stage_if.sv
// One pipeline register's worth of state between two stages
interface lc4_stage_if;

  logic             valid;  // Slot holds a live instruction
  lc4_pkg::word_t   pc;
  lc4_pkg::word_t   insn;
  lc4_pkg::ctrl_t   ctrl;   // Cleared in bubbles
  lc4_pkg::reg_sel_t rs;
  lc4_pkg::reg_sel_t rt;
  lc4_pkg::reg_sel_t rd;
  lc4_pkg::word_t   a;      // rs value, later result
  lc4_pkg::word_t   b;      // rt value, later store data or address

  // Upstream stage owns the register
  modport src (
    output valid,
    output pc,
    output insn,
    output ctrl,
    output rs, rt, rd,
    output a, b
  );

  // Downstream stage only looks
  modport dst (
    input valid,
    input pc,
    input insn,
    input ctrl,
    input rs, rt, rd,
    input a, b
  );

endinterface

//--- hw/lc4_writeback.sv
module lc4_writeback (
  input  logic              gwe,
  input  logic              i_rst,
  output logic              o_rf_we,         // Register-file write port
  output lc4_pkg::reg_sel_t o_rd,
  output lc4_pkg::word_t    o_wdata,
  output lc4_pkg::nzp_t     o_nzp,           // NZP after this instruction
  output logic              o_wb_valid,      // Trace of the retiring insn
  output lc4_pkg::word_t    o_wb_pc,
  output lc4_pkg::word_t    o_wb_insn,
  output logic              o_wb_rf_we,
  output lc4_pkg::reg_sel_t o_wb_rd,
  output lc4_pkg::word_t    o_wb_data,
  output lc4_pkg::nzp_t     o_wb_nzp,
  output logic              o_wb_dmem_we,
  output lc4_pkg::word_t    o_wb_dmem_addr,
  output lc4_pkg::word_t    o_wb_dmem_data,
  lc4_stage_if.dst          mw
);

  lc4_pkg::nzp_t nzp_q;      // Architectural NZP
  logic          nzp_set;

  // Bubbles arrive with cleared control, so the flags alone decide
  assign nzp_set = mw.ctrl.nzp_we;
  assign o_nzp   = nzp_set ? lc4_pkg::nzp_of(mw.a) : nzp_q;

  always_ff @(posedge gwe) begin
    if (i_rst)        nzp_q <= 3'b000;
    else if (nzp_set) nzp_q <= o_nzp;
  end

  assign o_rf_we = mw.ctrl.rf_we;
  assign o_rd    = mw.rd;
  assign o_wdata = mw.a;

  assign o_wb_valid     = mw.valid;
  assign o_wb_pc        = mw.pc;
  assign o_wb_insn      = mw.insn;
  assign o_wb_rf_we     = o_rf_we;
  assign o_wb_rd        = mw.rd;
  assign o_wb_data      = o_rf_we ? mw.a : '0;
  assign o_wb_nzp       = o_nzp;
  assign o_wb_dmem_we   = mw.ctrl.is_store;
  assign o_wb_dmem_addr = mw.b;
  assign o_wb_dmem_data = (mw.ctrl.is_load || mw.ctrl.is_store) ? mw.a : '0;

  // Decode and every stage register must keep bubbles free of write flags
  a_write_needs_valid : assert property (
    @(posedge gwe) disable iff (i_rst) o_wb_rf_we |-> o_wb_valid);

endmodule

//--- tb/lc4_ref_model.sv
`include "lc4_defs.svh"

// Instruction-level LC4 subset, one step per retired instruction
module lc4_ref_model;
  timeunit 1ns;
  timeprecision 1ps;

  logic [15:0] pc;                    // Next instruction on the model's path
  logic [15:0] regs [8];
  logic [2:0]  nzp;
  logic [15:0] mem [logic [15:0]];    // Words stored so far
  int          count;                 // Instructions stepped

  // Expected trace of the last step
  logic        e_taken;
  logic        e_rf_we;
  logic [2:0]  e_rd;
  logic [15:0] e_data;
  logic [2:0]  e_nzp;
  logic        e_dmem_we;
  logic [15:0] e_addr;
  logic [15:0] e_mdata;

  // Power-on data memory, every address bit matters
  function automatic logic [15:0] fill_word(input logic [15:0] a);
    return {a[6:0], a[15:7]} ^ 16'h3c5a;
  endfunction

  function automatic logic [15:0] mem_read(input logic [15:0] a);
    return mem.exists(a) ? mem[a] : fill_word(a);
  endfunction

  function automatic int mem_size();
    return mem.num();
  endfunction

  function automatic logic [2:0] cc(input logic [15:0] v);
    if (v[15]) return 3'b100;           // Sign bit set
    if (v == 16'h0000) return 3'b010;
    return 3'b001;
  endfunction

  task automatic reset_state();
    pc    = `LC4_RESET_PC;
    nzp   = 3'b000;
    count = 0;
    mem.delete();
  endtask

  task automatic step(input logic [15:0] insn);
    logic [15:0] s5;
    logic [15:0] s6;
    logic [15:0] s9;
    logic [15:0] v;
    s5        = {{11{insn[4]}}, insn[4:0]};
    s6        = {{10{insn[5]}}, insn[5:0]};
    s9        = {{7{insn[8]}}, insn[8:0]};
    v         = 16'h0000;
    e_taken   = 1'b0;
    e_rf_we   = 1'b0;
    e_rd      = insn[11:9];
    e_data    = 16'h0000;        // Zero unless a register is written
    e_dmem_we = 1'b0;
    e_addr    = 16'h0000;
    e_mdata   = 16'h0000;
    case (insn[15:12])
      `LC4_OP_BR: e_taken = |(insn[11:9] & nzp);
      `LC4_OP_ARITH: begin
        e_rf_we = insn[5] || insn[5:3] == `LC4_SUB_ADD;   // Other subcodes retire as no-ops
        v       = regs[insn[8:6]] + (insn[5] ? s5 : regs[insn[2:0]]);
      end
      `LC4_OP_LOGIC: begin
        e_rf_we = insn[5] || insn[5:3] == `LC4_SUB_AND;
        v       = regs[insn[8:6]] & (insn[5] ? s5 : regs[insn[2:0]]);
      end
      `LC4_OP_LDR: begin
        e_addr  = regs[insn[8:6]] + s6;
        v       = mem_read(e_addr);
        e_mdata = v;
        e_rf_we = 1'b1;
      end
      `LC4_OP_STR: begin
        e_addr       = regs[insn[8:6]] + s6;
        e_mdata      = regs[insn[11:9]];   // Data register in the rd field
        e_dmem_we    = 1'b1;
        mem[e_addr]  = e_mdata;
      end
      `LC4_OP_CONST: begin
        v       = s9;
        e_rf_we = 1'b1;
      end
      default: e_rf_we = 1'b0;
    endcase
    if (e_rf_we) begin
      regs[insn[11:9]] = v;
      nzp              = cc(v);   // Every writer sets NZP
      e_data           = v;
    end
    e_nzp = nzp;
    pc    = e_taken ? pc + 16'd1 + s9 : pc + 16'd1;
    count++;
  endtask

endmodule

//--- tb/lc4_tb.sv
`include "lc4_defs.svh"

module lc4_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          PROG_LEN = 200;
  localparam logic [15:0] PROG_END = `LC4_RESET_PC + PROG_LEN;  // First word past the image

  logic        gwe;
  logic        i_rst;
  logic [15:0] o_imem_addr;
  logic [15:0] i_imem_rdata;
  logic [15:0] o_dmem_addr;
  logic [15:0] o_dmem_wdata;
  logic        o_dmem_we;
  logic [15:0] i_dmem_rdata;
  logic        o_wb_valid;
  logic [15:0] o_wb_pc;
  logic [15:0] o_wb_insn;
  logic        o_wb_rf_we;
  logic [2:0]  o_wb_rd;
  logic [15:0] o_wb_data;
  logic [2:0]  o_wb_nzp;
  logic        o_wb_dmem_we;
  logic [15:0] o_wb_dmem_addr;
  logic [15:0] o_wb_dmem_data;

  logic [15:0] prog [PROG_LEN];          // Program image at the reset PC
  logic [15:0] dmem [logic [15:0]];      // Words written by the DUT
  int          checks [5];               // reset, alu, memory, branch, path
  int          errors [5];
  int          n_seen [4];               // ALU writes, memory ops, taken, not taken
  int          dut_count;                // DUT retires inside the image
  int          tot_chk;
  int          tot_err;
  bit          after_branch;
  bit          stop;
  bit          ok;
  logic [15:0] key;

  lc4_pipeline i_lc4_pipeline (.*);
  lc4_ref_model i_ref_model ();

  initial begin
    gwe = 1'b0;
    forever #20 gwe = ~gwe;
  end

  function automatic logic [15:0] imem_read(input logic [15:0] a);
    if (a >= `LC4_RESET_PC && a < PROG_END) return prog[a - `LC4_RESET_PC];
    return `LC4_NOP_INSN;                  // Outside the image
  endfunction

  // Store lands at the edge and reads follow the address 2 ns later
  always begin
    @(posedge gwe);
    if (o_dmem_we === 1'b1) dmem[o_dmem_addr] = o_dmem_wdata;
    #2;
    i_imem_rdata = imem_read(o_imem_addr);
    if ($isunknown(o_dmem_addr))       i_dmem_rdata = 16'h0000;
    else if (dmem.exists(o_dmem_addr)) i_dmem_rdata = dmem[o_dmem_addr];
    else                               i_dmem_rdata = i_ref_model.fill_word(o_dmem_addr);
  end

  // Independent retire count
  always @(negedge gwe) begin
    if (o_wb_valid === 1'b1 && o_wb_pc >= `LC4_RESET_PC && o_wb_pc < PROG_END) dut_count++;
  end

  task automatic check_eq(input string name, input logic [15:0] got, input logic [15:0] exp,
                          input int cat);
    checks[cat]++;
    if (got !== exp) begin
      errors[cat]++;
      $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic build_program();
    logic [2:0] rd;
    logic [2:0] rs;
    logic [2:0] rt;
    logic [2:0] base;
    logic [2:0] last;
    logic [8:0] imm;
    logic [5:0] off;
    int         k;
    bit         use_next;
    last     = 3'd0;
    use_next = 1'b0;
    for (int i = 0; i < PROG_LEN; i++) begin
      rd  = $urandom % 7;                 // R7 stays the memory base
      rs  = $urandom;
      if ($urandom % 2) rs = last;         // Back-to-back dependence
      rt   = $urandom;
      imm  = $urandom;
      base = ($urandom % 4 != 0) ? 3'd7 : rs;
      off  = {{3{imm[2]}}, imm[2:0]};      // Small window so loads meet stores
      k    = use_next ? 16 + $urandom % 2 : $urandom % 13;
      use_next = 1'b0;
      if (i < 8) begin
        rd      = i[2:0];
        prog[i] = {`LC4_OP_CONST, rd, imm};   // Every register gets a value first
      end else if (i >= PROG_LEN - 8) begin
        prog[i] = `LC4_NOP_INSN;             // Tail where all branches end up
      end else begin
        case (k)
          0, 1: prog[i] = {`LC4_OP_ARITH, rd, rs, `LC4_SUB_ADD, rt};
          2:    prog[i] = {`LC4_OP_LOGIC, rd, rs, `LC4_SUB_AND, rt};
          3:    prog[i] = {`LC4_OP_ARITH, rd, rs, 1'b1, imm[4:0]};
          4:    prog[i] = {`LC4_OP_LOGIC, rd, rs, 1'b1, imm[4:0]};
          5:    prog[i] = {`LC4_OP_CONST, rd, imm};
          6, 7: begin
            prog[i]  = {`LC4_OP_LDR, rd, base, off};
            use_next = ($urandom % 2) == 1;
          end
          8:     prog[i] = {`LC4_OP_STR, rt, base, off};
          9, 10: prog[i] = {`LC4_OP_BR, imm[8:6], 7'd0, imm[1:0]};   // Forward only
          11:    prog[i] = {`LC4_OP_ARITH, rd, rs, 1'b0, imm[4], 1'b1, rt};  // Dropped subcode
          12:    prog[i] = {4'b1010, rd, imm};                          // Dropped opcode
          16:    prog[i] = {`LC4_OP_ARITH, rd, last, `LC4_SUB_ADD, rt};  // Load feeds next
          default: prog[i] = {`LC4_OP_STR, last, base, off};          // Loaded word stored
        endcase
      end
      last = rd;
    end
  endtask

  // Poll for the next retire and optionally watch for an early store
  task automatic wait_retire(input bit watch_dmem, output bit got);
    got = 1'b0;
    for (int n = 0; n < 2000 && !got; n++) begin
      @(negedge gwe);
      if (o_wb_valid === 1'b1) got = 1'b1;
      else if (watch_dmem) check_eq("o_dmem_we", o_dmem_we, 16'h0000, 0);
    end
    if (!got) $display("Timeout: nothing retired within 2000 cycles");
  endtask

  task automatic check_retire();
    logic [15:0] insn;
    int          cat;
    insn = imem_read(i_ref_model.pc);     // Model's own path through the image
    check_eq("o_wb_pc", o_wb_pc, i_ref_model.pc, after_branch ? 3 : 4);
    if (o_wb_pc !== i_ref_model.pc) begin
      $display("Retired PC left the expected path, run stopped");
      stop = 1'b1;
    end
    i_ref_model.step(insn);
    case (insn[15:12])
      `LC4_OP_BR: cat = 3;
      `LC4_OP_ARITH, `LC4_OP_LOGIC, `LC4_OP_CONST: cat = 1;
      `LC4_OP_LDR, `LC4_OP_STR: cat = 2;
      default: cat = 4;
    endcase
    after_branch = cat == 3 && insn[11:9] != 3'b000;
    if (after_branch) n_seen[i_ref_model.e_taken ? 2 : 3]++;
    if (cat == 1 && i_ref_model.e_rf_we) n_seen[0]++;
    if (cat == 2) n_seen[1]++;
    check_eq("o_wb_insn", o_wb_insn, insn, 4);
    check_eq("o_wb_rf_we", o_wb_rf_we, i_ref_model.e_rf_we, cat);
    if (i_ref_model.e_rf_we) check_eq("o_wb_rd", o_wb_rd, i_ref_model.e_rd, cat);
    check_eq("o_wb_data", o_wb_data, i_ref_model.e_data, cat);
    check_eq("o_wb_nzp", o_wb_nzp, i_ref_model.e_nzp, cat);
    check_eq("o_wb_dmem_we", o_wb_dmem_we, i_ref_model.e_dmem_we, cat);
    check_eq("o_wb_dmem_addr", o_wb_dmem_addr, i_ref_model.e_addr, cat);
    check_eq("o_wb_dmem_data", o_wb_dmem_data, i_ref_model.e_mdata, cat);
  endtask

  initial begin
    void'($urandom(32'h553a));
    i_rst        = 1'b1;
    i_imem_rdata = `LC4_NOP_INSN;
    i_dmem_rdata = 16'h0000;
    dut_count    = 0;
    stop         = 1'b0;
    after_branch = 1'b0;
    build_program();
    i_ref_model.reset_state();
    repeat (8) @(posedge gwe);
    #2 i_rst = 1'b0;
    @(negedge gwe);
    check_eq("o_wb_valid", o_wb_valid, 16'h0000, 0);   // Pipeline empty out of reset
    check_eq("o_dmem_we", o_dmem_we, 16'h0000, 0);
    check_eq("o_imem_addr", o_imem_addr, `LC4_RESET_PC, 0);
    wait_retire(1'b1, ok);
    if (ok) check_eq("o_wb_pc", o_wb_pc, `LC4_RESET_PC, 0);
    $display("reset: %0d checks, %0d errors", checks[0], errors[0]);
    while (ok && !stop) begin
      check_retire();
      if (i_ref_model.pc == PROG_END) stop = 1'b1;
      else wait_retire(1'b0, ok);
    end
    #1;
    if (ok) begin
      // Younger slots leave the pipeline before the image count is taken
      for (int n = 0; n < 8; n++) @(negedge gwe);
      check_eq("retired count", dut_count, i_ref_model.count, 4);
      check_eq("dmem entries", dmem.num(), i_ref_model.mem_size(), 2);
      if (dmem.first(key)) begin
        do check_eq("dmem word", dmem[key], i_ref_model.mem_read(key), 2);
        while (dmem.next(key));
      end
    end
    $display("alu: %0d writes, %0d checks, %0d errors", n_seen[0], checks[1], errors[1]);
    $display("memory: %0d loads and stores, %0d checks, %0d errors", n_seen[1], checks[2],
             errors[2]);
    $display("branch: %0d taken, %0d not taken, %0d checks, %0d errors", n_seen[2], n_seen[3],
             checks[3], errors[3]);
    $display("path: %0d retired, %0d checks, %0d errors", dut_count, checks[4], errors[4]);
    tot_chk = checks.sum();
    tot_err = errors.sum();
    $display("Totals: %0d checks, %0d errors", tot_chk, tot_err);
    if (ok && tot_err == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+hw
hw/lc4_pkg.sv
hw/lc4_stage_if.sv
hw/lc4_fetch.sv
hw/lc4_decode.sv
hw/lc4_execute.sv
hw/lc4_memory.sv
hw/lc4_writeback.sv
hw/lc4_pipeline.sv
tb/lc4_ref_model.sv
tb/lc4_tb.sv
